//--- rtl/mist_defs.svh
`ifndef MIST_DEFS_SVH
`define MIST_DEFS_SVH

// widths.
`define MIST_STATUS_W 32
`define MIST_AUDIO_W 7

// spi commands from the board controller.
`define MIST_CMD_BUTTONS 8'h01
`define MIST_CMD_STATUS 8'h1E

// ps/2 set 2 scancodes.
`define MIST_KEY_COIN 8'h2E
`define MIST_KEY_START 8'h16
`define MIST_KEY_GAS 8'h1C

// ps/2 prefixes.
`define MIST_PS2_BREAK 8'hF0
`define MIST_PS2_EXT 8'hE0

`endif

//--- rtl/mist_pkg.sv
package mist_pkg;

	// what the game core presents each clk_24 cycle.
	typedef struct packed {
		logic [1:0] level;
		logic       hs;
		logic       vs;
		logic       hblank;
		logic       vblank;
	} core_video_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_t;

	// player controls, all active high.
	typedef struct packed {
		logic coin;
		logic start;
		logic gas;
		logic test;
	} ctrl_t;

	// encoding of status bits 4:3.
	typedef enum logic [1:0] {
		SCAN_NONE  = 2'd0,
		SCAN_HQ    = 2'd1,
		SCAN_CRT25 = 2'd2,
		SCAN_CRT50 = 2'd3
	} scan_mode_e;

endpackage

//--- rtl/user_io_spi.sv
`timescale 1ns/1ps
`include "mist_defs.svh"

module user_io_spi (
	input  logic                      clk_24,
	input  logic                      rst,
	input  logic                      spi_sck,
	input  logic                      spi_di,
	input  logic                      spi_ss,
	output logic [`MIST_STATUS_W-1:0] status,
	output logic [1:0]                buttons
);

	logic [1:0]                  sck_q;
	logic [1:0]                  di_q;
	logic [1:0]                  ss_q;
	logic                        sck_last;
	logic                        sck_rise;
	logic                        ss_hi;
	logic [7:0]                  shift;
	logic [7:0]                  shift_next;
	logic [7:0]                  cmd;
	logic [`MIST_STATUS_W-9:0]   hold;
	logic [2:0]                  bit_cnt;
	logic [2:0]                  byte_cnt;

	always_ff @(posedge clk_24) begin
		sck_q    <= {sck_q[0], spi_sck};
		di_q     <= {di_q[0], spi_di};
		ss_q     <= {ss_q[0], spi_ss};
		sck_last <= sck_q[1];
	end

	assign sck_rise   = sck_q[1] & ~sck_last;
	assign ss_hi      = ss_q[1];
	assign shift_next = {shift[6:0], di_q[1]};

	// byte data, command and status holding register.
	always_ff @(posedge clk_24) begin
		if (!ss_hi && sck_rise) begin
			shift <= shift_next;
			if (bit_cnt == 3'd7) begin
				if (byte_cnt == 3'd0) begin
					cmd <= shift_next;
				end else if (cmd == `MIST_CMD_STATUS) begin
					case (byte_cnt)
						3'd1: hold[7:0]   <= shift_next;
						3'd2: hold[15:8]  <= shift_next;
						3'd3: hold[23:16] <= shift_next;
						default: ;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk_24) begin
		if (rst) begin
			bit_cnt  <= '0;
			byte_cnt <= '0;
			status   <= '0;
			buttons  <= '0;
		end else if (ss_hi) begin
			// deselect aborts any partial transfer.
			bit_cnt  <= '0;
			byte_cnt <= '0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				if (byte_cnt != 3'd7) begin
					byte_cnt <= byte_cnt + 3'd1;
				end
				if (cmd == `MIST_CMD_BUTTONS && byte_cnt == 3'd1) begin
					buttons <= shift_next[1:0];
				end
				if (cmd == `MIST_CMD_STATUS && byte_cnt == 3'd4) begin
					status <= {shift_next, hold};
				end
			end
		end
	end

	a_no_byte_adv_deselected: assert property (@(posedge clk_24) disable iff (rst)
		ss_hi |=> !(byte_cnt > $past(byte_cnt)));

endmodule

//--- rtl/ps2_keyboard.sv
`timescale 1ns/1ps
`include "mist_defs.svh"

module ps2_keyboard (
	input  logic            clk_24,
	input  logic            rst,
	input  logic            ps2_clk,
	input  logic            ps2_data,
	output mist_pkg::ctrl_t keys
);

	logic [1:0]  clk_q;
	logic [1:0]  data_q;
	logic        clk_last;
	logic        clk_fall;
	logic [10:0] frame;
	logic [10:0] frame_next;
	logic [3:0]  bit_cnt;
	logic [7:0]  code;
	logic        frame_ok;
	logic        brk;
	logic        ext;

	always_ff @(posedge clk_24) begin
		clk_q    <= {clk_q[0], ps2_clk};
		data_q   <= {data_q[0], ps2_data};
		clk_last <= clk_q[1];
	end

	assign clk_fall   = clk_last & ~clk_q[1];
	// lsb first, so the start bit ends up in bit 0.
	assign frame_next = {data_q[1], frame[10:1]};
	assign code       = frame_next[8:1];
	// odd parity over data and parity, plus stop.
	assign frame_ok   = (^frame_next[9:1]) & frame_next[10];

	always_ff @(posedge clk_24) begin
		if (clk_fall) begin
			frame <= frame_next;
		end
	end

	always_ff @(posedge clk_24) begin
		if (rst) begin
			bit_cnt <= '0;
			brk     <= 1'b0;
			ext     <= 1'b0;
			keys    <= '0;
		end else if (clk_fall) begin
			if (bit_cnt == 4'd10) begin
				bit_cnt <= '0;
				if (frame_ok) begin
					if (code == `MIST_PS2_BREAK) begin
						brk <= 1'b1;
					end else if (code == `MIST_PS2_EXT) begin
						ext <= 1'b1;
					end else begin
						brk <= 1'b0;
						ext <= 1'b0;
						// extended codes map to nothing.
						if (!ext) begin
							case (code)
								`MIST_KEY_COIN:  keys.coin  <= ~brk;
								`MIST_KEY_START: keys.start <= ~brk;
								`MIST_KEY_GAS:   keys.gas   <= ~brk;
								default: ;
							endcase
						end
					end
				end
			end else if (bit_cnt != 4'd0 || !data_q[1]) begin
				// idle until a start bit.
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	a_bit_cnt_range: assert property (@(posedge clk_24) disable iff (rst)
		bit_cnt <= 4'd10);

endmodule

//--- rtl/video_mixer.sv
`timescale 1ns/1ps

module video_mixer (
	input  logic                  clk_24,
	input  logic                  rst,
	input  mist_pkg::scan_mode_e  scan_mode,
	input  mist_pkg::core_video_t video_in,
	output mist_pkg::vga_t        vga
);

	logic       hs_last;
	logic       line_odd;
	logic       blank;
	logic [5:0] level_wide;
	logic [5:0] shaded;

	assign level_wide = {3{video_in.level}};
	assign blank      = video_in.hblank | video_in.vblank;

	// darken odd lines for the crt look.
	always_comb begin
		shaded = level_wide;
		if (line_odd) begin
			case (scan_mode)
				mist_pkg::SCAN_CRT25: shaded = level_wide - (level_wide >> 2);
				mist_pkg::SCAN_CRT50: shaded = level_wide >> 1;
				default:              shaded = level_wide;
			endcase
		end
	end

	always_ff @(posedge clk_24) begin
		if (rst) begin
			hs_last  <= 1'b0;
			line_odd <= 1'b0;
			vga      <= '0;
		end else begin
			hs_last <= video_in.hs;
			if (video_in.vs) begin
				line_odd <= 1'b0;
			end else if (video_in.hs && !hs_last) begin
				line_odd <= ~line_odd;
			end
			vga.r  <= blank ? 6'd0 : shaded;
			vga.g  <= blank ? 6'd0 : shaded;
			vga.b  <= blank ? 6'd0 : shaded;
			vga.hs <= video_in.hs;
			vga.vs <= video_in.vs;
		end
	end

	a_blank_is_black: assert property (@(posedge clk_24) disable iff (rst)
		blank |=> (vga.r == 6'd0 && vga.g == 6'd0 && vga.b == 6'd0));

endmodule

//--- rtl/sigma_delta_dac.sv
`timescale 1ns/1ps
`include "mist_defs.svh"

module sigma_delta_dac (
	input  logic                     clk_24,
	input  logic                     rst,
	input  logic [`MIST_AUDIO_W-1:0] sample,
	output logic                     dout
);

	logic [`MIST_AUDIO_W-1:0] acc;
	logic [`MIST_AUDIO_W:0]   sum;

	// carry out of the accumulator is the pulse stream.
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_24) begin
		if (rst) begin
			acc  <= '0;
			dout <= 1'b0;
		end else begin
			acc  <= sum[`MIST_AUDIO_W-1:0];
			dout <= sum[`MIST_AUDIO_W];
		end
	end

endmodule

//--- rtl/sprint1_mist.sv
`timescale 1ns/1ps
`include "mist_defs.svh"

module sprint1_mist (
	input  logic                     clk_24,
	input  logic                     rst,
	input  logic                     SPI_SCK,
	input  logic                     SPI_DI,
	input  logic                     SPI_SS2,
	input  logic                     ps2_kbd_clk,
	input  logic                     ps2_kbd_data,
	input  mist_pkg::core_video_t    core_video,
	input  logic [`MIST_AUDIO_W-1:0] core_audio,
	output mist_pkg::vga_t           VGA,
	output logic                     AUDIO_L,
	output logic                     AUDIO_R,
	output logic                     LED,
	output mist_pkg::ctrl_t          core_ctrl,
	output logic                     core_reset_n
);

	logic [`MIST_STATUS_W-1:0] status;
	logic [1:0]                buttons;
	mist_pkg::ctrl_t           keys;
	mist_pkg::scan_mode_e      scan_mode;

	user_io_spi i_user_io_spi (
		.clk_24  (clk_24),
		.rst     (rst),
		.spi_sck (SPI_SCK),
		.spi_di  (SPI_DI),
		.spi_ss  (SPI_SS2),
		.status  (status),
		.buttons (buttons)
	);

	ps2_keyboard i_ps2_keyboard (
		.clk_24   (clk_24),
		.rst      (rst),
		.ps2_clk  (ps2_kbd_clk),
		.ps2_data (ps2_kbd_data),
		.keys     (keys)
	);

	// status 0 is reset, 6 is the osd reset entry.
	assign core_reset_n = ~(rst | status[0] | status[6] | buttons[1]);
	assign core_ctrl    = '{coin: keys.coin, start: keys.start, gas: keys.gas, test: status[1]};
	assign scan_mode    = mist_pkg::scan_mode_e'(status[4:3]);
	assign LED          = buttons[0];

	video_mixer i_video_mixer (
		.clk_24    (clk_24),
		.rst       (rst),
		.scan_mode (scan_mode),
		.video_in  (core_video),
		.vga       (VGA)
	);

	sigma_delta_dac i_sigma_delta_dac (
		.clk_24 (clk_24),
		.rst    (rst),
		.sample (core_audio),
		.dout   (AUDIO_L)
	);

	assign AUDIO_R = AUDIO_L;

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/1ps
`include "mist_defs.svh"

module tb_checker (
	input  logic                     clk_24,
	input  logic                     rst,
	input  logic                     quiet,
	input  logic                     done,
	input  logic [31:0]              status_m,
	input  logic [1:0]               buttons_m,
	input  logic [7:0]               kb_code,
	input  logic                     kb_good,
	input  logic                     kb_evt,
	input  mist_pkg::core_video_t    core_video,
	input  logic [`MIST_AUDIO_W-1:0] core_audio,
	input  mist_pkg::vga_t           vga,
	input  logic                     audio_l,
	input  logic                     audio_r,
	input  logic                     led,
	input  mist_pkg::ctrl_t          core_ctrl,
	input  logic                     core_reset_n,
	output int                       mismatch_errs,
	output int                       other_errs
);

	mist_pkg::vga_t           m_vga;
	mist_pkg::ctrl_t          keys_m;
	mist_pkg::ctrl_t          exp_ctrl;
	logic                     exp_rst_n;
	logic [5:0]               w;
	logic                     m_odd;
	logic                     m_hs_last;
	logic                     k_brk;
	logic                     k_ext;
	logic                     evt_q;
	logic                     a_ok;
	logic [`MIST_AUDIO_W-1:0] a_prev;
	int                       run;
	int                       ones;
	int                       n_mis = 0;
	int                       n_oth = 0;

	assign mismatch_errs = n_mis;
	assign other_errs    = n_oth;

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_mis++;
		$display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
	endtask

	always @(posedge clk_24) begin
		if (rst) begin
			m_vga     = '0;
			m_odd     = 1'b0;
			m_hs_last = 1'b0;
			keys_m    = '0;
			k_brk     = 1'b0;
			k_ext     = 1'b0;
			evt_q     = kb_evt;
			a_ok      = 1'b0;
			run       = 0;
			ones      = 0;
		end else begin
			if (quiet) begin
				exp_ctrl      = keys_m;
				exp_ctrl.test = status_m[1];
				exp_rst_n     = ~(status_m[0] | status_m[6] | buttons_m[1]);
				if (vga !== m_vga)
					mismatch("video", m_vga, vga);
				if (core_reset_n !== exp_rst_n)
					mismatch("core reset", exp_rst_n, core_reset_n);
				if (core_ctrl !== exp_ctrl)
					mismatch("controls", exp_ctrl, core_ctrl);
				if (led !== buttons_m[0])
					mismatch("led", buttons_m[0], led);
			end
			if (audio_r !== audio_l) begin
				n_oth++;
				$display("audio right channel does not follow the left channel");
			end
			// the pulse seen now belongs to the previous sample.
			if (a_ok) begin
				ones += audio_l;
				run++;
				if (run == 128) begin
					if (ones != a_prev)
						mismatch("audio ones per 128", a_prev, ones);
					run  = 0;
					ones = 0;
				end
			end
			if (!a_ok || core_audio != a_prev) begin
				run  = 0;
				ones = 0;
			end
			a_prev = core_audio;
			a_ok   = 1'b1;
			w = {3{core_video.level}};
			if (m_odd && status_m[4:3] == mist_pkg::SCAN_CRT25)
				w = w - (w >> 2);
			else if (m_odd && status_m[4:3] == mist_pkg::SCAN_CRT50)
				w = w >> 1;
			if (core_video.hblank || core_video.vblank)
				w = '0;
			m_vga = '{r: w, g: w, b: w, hs: core_video.hs, vs: core_video.vs};
			if (core_video.vs)
				m_odd = 1'b0;
			else if (core_video.hs && !m_hs_last)
				m_odd = !m_odd;
			m_hs_last = core_video.hs;
			if (kb_evt != evt_q && kb_good) begin
				if (kb_code == `MIST_PS2_BREAK) begin
					k_brk = 1'b1;
				end else if (kb_code == `MIST_PS2_EXT) begin
					k_ext = 1'b1;
				end else begin
					if (!k_ext && kb_code == `MIST_KEY_COIN)
						keys_m.coin = !k_brk;
					if (!k_ext && kb_code == `MIST_KEY_START)
						keys_m.start = !k_brk;
					if (!k_ext && kb_code == `MIST_KEY_GAS)
						keys_m.gas = !k_brk;
					k_brk = 1'b0;
					k_ext = 1'b0;
				end
			end
			evt_q = kb_evt;
		end
	end

	always @(posedge done) begin
		$display("checker: %0d mismatch errors, %0d other errors", n_mis, n_oth);
	end

endmodule

//--- sim/tb_sprint1_mist.sv
`timescale 1ns/1ps
`include "mist_defs.svh"

module tb_sprint1_mist;

	localparam int HALF = 6;
	localparam int N_STAT = 8;
	localparam int N_KEY = 40;
	// status, abort, buttons, audio and keyboard phases in clk_24 cycles.
	localparam int PLAN_CYC = 20 + (N_STAT + 1) * 780 + 4 * 270 + 6 * 300 + N_KEY * 3 * 150;

	logic                     clk_24;
	logic                     rst;
	logic                     spi_sck;
	logic                     spi_di;
	logic                     spi_ss2;
	logic                     ps2_clk;
	logic                     ps2_data;
	mist_pkg::core_video_t    core_video;
	logic [`MIST_AUDIO_W-1:0] core_audio;
	mist_pkg::vga_t           vga;
	logic                     audio_l;
	logic                     audio_r;
	logic                     led;
	mist_pkg::ctrl_t          core_ctrl;
	logic                     core_reset_n;
	logic                     quiet;
	logic                     done;
	logic [31:0]              status_m;
	logic [1:0]               buttons_m;
	logic [7:0]               kb_code;
	logic                     kb_good;
	logic                     kb_evt;
	int                       mismatch_errs;
	int                       other_errs;
	logic [15:0]              lfsr = 16'd39;
	logic [31:0]              word;
	logic [7:0]               code;
	int                       vcnt;

	sprint1_mist i_sprint1_mist (
		.clk_24, .rst, .SPI_SCK(spi_sck), .SPI_DI(spi_di), .SPI_SS2(spi_ss2),
		.ps2_kbd_clk(ps2_clk), .ps2_kbd_data(ps2_data), .core_video, .core_audio,
		.VGA(vga), .AUDIO_L(audio_l), .AUDIO_R(audio_r), .LED(led), .core_ctrl, .core_reset_n
	);

	tb_checker i_tb_checker (.*);

	// fibonacci lfsr with taps 16 14 13 11.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_24);
	endtask

	task automatic settle();
		wait_cycles(8);
		quiet = 1'b1;
	endtask

	task automatic spi_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			spi_sck = 1'b0;
			spi_di  = b[i];
			wait_cycles(HALF);
			spi_sck = 1'b1;
			wait_cycles(HALF);
		end
	endtask

	// command, then n data bytes, least significant first.
	task automatic spi_transfer(input logic [7:0] cmd, input logic [31:0] data, input int n);
		quiet   = 1'b0;
		spi_ss2 = 1'b0;
		wait_cycles(HALF);
		spi_byte(cmd);
		for (int i = 0; i < n; i++) begin
			spi_byte(data[8*i +: 8]);
		end
		spi_sck = 1'b0;
		wait_cycles(HALF);
		spi_ss2 = 1'b1;
	endtask

	task automatic ps2_frame(input logic [7:0] c, input logic bad);
		logic [10:0] f;
		f     = {1'b1, (~^c) ^ bad, c, 1'b0};
		quiet = 1'b0;
		for (int i = 0; i < 11; i++) begin
			ps2_data = f[i];
			wait_cycles(HALF);
			ps2_clk = 1'b0;
			wait_cycles(HALF);
			ps2_clk = 1'b1;
		end
		kb_code = c;
		kb_good = !bad;
		kb_evt  = !kb_evt;
		settle();
	endtask

	initial begin
		clk_24 = 1'b0;
		forever #5 clk_24 = ~clk_24;
	end

	initial begin
		repeat (PLAN_CYC * 6 / 5) @(posedge clk_24);
		$display("timeout: run did not finish within %0d cycles", PLAN_CYC * 6 / 5);
		$display("TEST FAILED");
		$finish;
	end

	// synthetic core with 64-cycle lines and vs on one line in eight.
	initial begin
		core_video = '0;
		vcnt       = 0;
		forever begin
			@(negedge clk_24);
			core_video.level  = 2'(rand_bits(2));
			core_video.hs     = (vcnt % 64) < 8;
			core_video.vs     = (vcnt / 64) % 8 == 0;
			core_video.hblank = rand_bits(2) == 0;
			core_video.vblank = rand_bits(3) == 0;
			vcnt++;
		end
	end

	initial begin
		rst        = 1'b1;
		spi_sck    = 1'b0;
		spi_di     = 1'b0;
		spi_ss2    = 1'b1;
		ps2_clk    = 1'b1;
		ps2_data   = 1'b1;
		core_audio = '0;
		quiet      = 1'b0;
		done       = 1'b0;
		status_m   = '0;
		buttons_m  = '0;
		kb_code    = '0;
		kb_good    = 1'b0;
		kb_evt     = 1'b0;
		wait_cycles(8);
		rst = 1'b0;
		settle();
		for (int i = 0; i < N_STAT; i++) begin
			word      = rand_bits(32);
			word[4:3] = 2'(i);
			// the last word leaves the core running for the buttons phase.
			if (i == N_STAT - 1) begin
				word[0] = 1'b0;
				word[6] = 1'b0;
			end
			spi_transfer(`MIST_CMD_STATUS, word, 4);
			status_m = word;
			settle();
			wait_cycles(256);
		end
		// deselect after two data bytes.
		spi_transfer(`MIST_CMD_STATUS, rand_bits(32), 2);
		settle();
		wait_cycles(256);
		for (int i = 0; i < 4; i++) begin
			word      = rand_bits(8);
			word[1:0] = 2'(i);
			spi_transfer(`MIST_CMD_BUTTONS, word, 1);
			buttons_m = word[1:0];
			settle();
			wait_cycles(40);
		end
		for (int i = 0; i < 6; i++) begin
			core_audio = 7'(rand_bits(7));
			wait_cycles(300);
		end
		for (int i = 0; i < N_KEY; i++) begin
			word = rand_bits(2);
			// 8'h29 maps to no control.
			code = word == 0 ? `MIST_KEY_COIN : word == 1 ? `MIST_KEY_START :
				word == 2 ? `MIST_KEY_GAS : 8'h29;
			if (rand_bits(3) == 0)
				ps2_frame(`MIST_PS2_EXT, 1'b0);
			if (rand_bits(1) != 0)
				ps2_frame(`MIST_PS2_BREAK, 1'b0);
			ps2_frame(code, rand_bits(3) == 0);
		end
		@(posedge clk_24);
		#1;
		done = 1'b1;
		#1;
		if (mismatch_errs == 0 && other_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+rtl
rtl/mist_pkg.sv
rtl/user_io_spi.sv
rtl/ps2_keyboard.sv
rtl/video_mixer.sv
rtl/sigma_delta_dac.sv
rtl/sprint1_mist.sv
sim/tb_checker.sv
sim/tb_sprint1_mist.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the sprint1_mist testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_sprint1_mist -o tb_sim --Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST PASSED" "$log"; then
	exit 0
fi
exit 1
